/* rtl/rename_pkg.sv */
/*
 * Shared register tag types and sizes for the rename back end.
 * Assumes 32 architectural and 64 physical registers, so 32 tags are free at reset.
 */

`default_nettype none

package rename_pkg;

  // architectural and physical register file sizes
  localparam int num_arch_regs = 32;
  localparam int num_phys_regs = 64;

  // 5-bit architectural index
  typedef logic [$clog2(num_arch_regs)-1:0] arch_reg_t;

  // 6-bit physical tag
  typedef logic [$clog2(num_phys_regs)-1:0] phys_reg_t;

  // ROB control state
  // recovering is held while the tail walks back after a mispredict
  typedef enum logic {
    normal,
    recovering
  } rob_state_e;

endpackage

`default_nettype wire

/* rtl/rob_if.sv */
/*
 * Dispatch, retire and undo events from the ROB to the map table and free list.
 * All signals are driven by the ROB. rob_depth must be a power of two, 2 to 32.
 */

`timescale 1ns/1ns
`default_nettype none

interface rob_if #(
  parameter int rob_depth = 16
);

  logic                  alloc;
  rename_pkg::arch_reg_t alloc_dest;
  logic                  free_push;
  rename_pkg::phys_reg_t free_tag;
  logic                  undo;
  rename_pkg::arch_reg_t undo_dest;
  rename_pkg::phys_reg_t undo_tag_old;

  // the free list never runs dry only while the ROB holds at most 32 entries
  if (rob_depth < 2 || rob_depth > 32 || (rob_depth & (rob_depth - 1)) != 0) begin : g_bad_depth
    $error("rob_depth must be a power of two between 2 and 32");
  end

  modport rob (
    output alloc, alloc_dest, free_push, free_tag, undo, undo_dest, undo_tag_old
  );

  modport map (input alloc, alloc_dest, undo, undo_dest, undo_tag_old);

  modport free (input alloc, free_push, free_tag, undo);

endinterface

`default_nettype wire

/* rtl/map_table.sv */
/*
 * Architectural to physical map. Lookup is combinational; updates land at the edge.
 * Reset maps architectural register i to physical tag i.
 * Only one of alloc and undo may be high in a cycle.
 */

`timescale 1ns/1ns
`default_nettype none

module map_table (
  input  logic                  clock,
  input  logic                  reset,
  rob_if.map                    port,
  input  rename_pkg::arch_reg_t lookup_dest,
  output rename_pkg::phys_reg_t lookup_tag_old,
  input  rename_pkg::phys_reg_t alloc_tag
);

  rename_pkg::phys_reg_t map [rename_pkg::num_arch_regs];

  // current mapping of the dispatching destination, i.e. T_old
  assign lookup_tag_old = map[lookup_dest];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < rename_pkg::num_arch_regs; i++) begin
        map[i] <= rename_pkg::phys_reg_t'(i);
      end
    end else if (port.alloc) begin
      map[port.alloc_dest] <= alloc_tag;
    end else if (port.undo) begin
      // rollback puts back the mapping from before the undone dispatch
      map[port.undo_dest] <= port.undo_tag_old;
    end
  end

  // dispatch is stalled for the whole recovery walk
  a_no_alloc_during_undo: assert property (
    @(posedge clock) disable iff (reset)
    !(port.alloc && port.undo)
  ) else $error("map table saw alloc and undo in the same cycle");

endmodule

`default_nettype wire

/* rtl/free_list.sv */
/*
 * Circular queue of free physical tags, holding tags 32 to 63 in order at reset.
 * Undo rewinds the read pointer, so undone entries must come youngest first.
 * No empty flag, since a ROB of at most 32 entries can never drain it.
 */

`timescale 1ns/1ns
`default_nettype none

module free_list (
  input  logic                  clock,
  input  logic                  reset,
  rob_if.free                   port,
  output rename_pkg::phys_reg_t front_tag
);

  localparam int free_depth = rename_pkg::num_phys_regs - rename_pkg::num_arch_regs;
  localparam int ptr_w      = $clog2(free_depth);
  localparam int cnt_w      = $clog2(free_depth + 1);

  rename_pkg::phys_reg_t queue [free_depth];
  logic [ptr_w-1:0]      rd_ptr;
  logic [ptr_w-1:0]      wr_ptr;
  logic [cnt_w-1:0]      count;

  assign front_tag = queue[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= cnt_w'(free_depth);
      for (int i = 0; i < free_depth; i++) begin
        queue[i] <= rename_pkg::phys_reg_t'(rename_pkg::num_arch_regs + i);
      end
    end else begin
      if (port.alloc) begin
        rd_ptr <= rd_ptr + 1'b1;
      end else if (port.undo) begin
        // slot rd_ptr-1 still holds the undone entry's tag
        // as the write pointer stops at the oldest entry's slot
        rd_ptr <= rd_ptr - 1'b1;
      end
      if (port.free_push) begin
        queue[wr_ptr] <= port.free_tag;
        wr_ptr        <= wr_ptr + 1'b1;
      end
      count <= count + cnt_w'(port.free_push) + cnt_w'(port.undo) - cnt_w'(port.alloc);
    end
  end

  a_count_bound: assert property (
    @(posedge clock) disable iff (reset)
    count <= cnt_w'(free_depth)
  ) else $error("free list holds more tags than it has slots");

  // a drained free list means the ROB let in more entries than it has
  a_alloc_not_empty: assert property (
    @(posedge clock) disable iff (reset)
    port.alloc |-> count != '0
  ) else $error("free list allocated while empty");

endmodule

`default_nettype wire

/* rtl/reorder_buffer.sv */
/*
 * Circular ROB holding dest, T and T_old per entry. Retire trusts the head to be done.
 * A mispredict rolls back one entry per cycle from the tail down to branch_idx+1;
 * dispatch and retire are both held off meanwhile. A full ROB stalls even on retire.
 */

`timescale 1ns/1ns
`default_nettype none

module reorder_buffer #(
  parameter int rob_depth = 16
) (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               dispatch,
  input  logic                               retire,
  input  logic                               mispredict,
  input  rename_pkg::arch_reg_t              dispatch_dest,
  input  logic [$clog2(rob_depth)-1:0]       branch_idx,
  input  rename_pkg::phys_reg_t              new_tag,
  input  rename_pkg::phys_reg_t              new_tag_old,
  rob_if.rob                                 port,
  output logic [$clog2(rob_depth)-1:0]       dispatch_rob_idx,
  output logic [$clog2(rob_depth)-1:0]       head_idx,
  output logic                               stall,
  output logic                               retire_strobe,
  output logic                               recovering,
  output rename_pkg::phys_reg_t              retire_tag_old
);

  localparam int idx_w = $clog2(rob_depth);
  localparam int cnt_w = idx_w + 1;

  // entry payload, only valid is reset
  logic                  valid   [rob_depth];
  rename_pkg::arch_reg_t dest    [rob_depth];
  rename_pkg::phys_reg_t tag     [rob_depth];
  rename_pkg::phys_reg_t tag_old [rob_depth];

  logic [idx_w-1:0]       head;
  logic [idx_w-1:0]       tail;
  logic [cnt_w-1:0]       count;
  logic [idx_w-1:0]       target;
  rename_pkg::rob_state_e state;

  logic             full;
  logic             empty;
  logic             mispredict_ok;
  logic             start_recovery;
  logic             accept_dispatch;
  logic             accept_retire;
  logic [idx_w-1:0] undo_idx;

  assign full          = count == cnt_w'(rob_depth);
  assign empty         = count == '0;
  assign recovering    = state == rename_pkg::recovering;
  assign stall         = full || recovering;
  assign mispredict_ok = mispredict && !recovering;

  // nothing to walk when the branch is already the youngest entry
  assign start_recovery  = mispredict_ok && (idx_w'(branch_idx + 1'b1) != tail);
  assign accept_dispatch = dispatch && !stall && !mispredict_ok;
  assign accept_retire   = retire && !empty && !recovering;
  assign undo_idx        = tail - 1'b1;

  assign dispatch_rob_idx = tail;
  assign head_idx         = head;
  assign retire_strobe    = accept_retire;
  assign retire_tag_old   = tag_old[head];

  assign port.alloc        = accept_dispatch;
  assign port.alloc_dest   = dispatch_dest;
  assign port.free_push    = accept_retire;
  assign port.free_tag     = tag_old[head];
  assign port.undo         = recovering;
  assign port.undo_dest    = dest[undo_idx];
  assign port.undo_tag_old = tag_old[undo_idx];

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      state <= rename_pkg::normal;
      for (int i = 0; i < rob_depth; i++) begin
        valid[i] <= 1'b0;
      end
    end else begin
      if (accept_dispatch) begin
        valid[tail] <= 1'b1;
        tail        <= tail + 1'b1;
      end
      if (accept_retire) begin
        valid[head] <= 1'b0;
        head        <= head + 1'b1;
      end
      if (recovering) begin
        valid[undo_idx] <= 1'b0;
        tail            <= undo_idx;
        // last undo when the entry just after the branch comes off
        if (undo_idx == target) begin
          state <= rename_pkg::normal;
        end
      end else if (start_recovery) begin
        state <= rename_pkg::recovering;
      end
      count <= count + cnt_w'(accept_dispatch) - cnt_w'(accept_retire) - cnt_w'(recovering);
    end
  end

  always_ff @(posedge clock) begin
    if (accept_dispatch) begin
      dest[tail]    <= dispatch_dest;
      tag[tail]     <= new_tag;
      tag_old[tail] <= new_tag_old;
    end
    if (start_recovery) begin
      target <= idx_w'(branch_idx + 1'b1);
    end
  end

  a_branch_valid: assert property (
    @(posedge clock) disable iff (reset)
    mispredict_ok |-> valid[branch_idx]
  ) else $error("mispredict names an empty ROB slot");

  a_count_bound: assert property (
    @(posedge clock) disable iff (reset)
    count <= cnt_w'(rob_depth)
  ) else $error("ROB count beyond depth");

  // the free list rewind must bring back exactly the undone entry's tag
  a_undo_tag: assert property (
    @(posedge clock) disable iff (reset)
    recovering |=> new_tag == $past(tag[undo_idx])
  ) else $error("free list front differs from undone tag");

endmodule

`default_nettype wire

/* rtl/rename_core.sv */
/*
 * Register rename back end: map table, free list and ROB.
 * rob_depth must be a power of two from 2 to 32. No back-pressure anywhere.
 */

`timescale 1ns/1ns
`default_nettype none

module rename_core #(
  parameter int rob_depth = 16
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         dispatch,
  input  rename_pkg::arch_reg_t        dispatch_dest,
  input  logic                         retire,
  input  logic                         mispredict,
  input  logic [$clog2(rob_depth)-1:0] branch_idx,
  output rename_pkg::phys_reg_t        dispatch_tag,
  output rename_pkg::phys_reg_t        dispatch_tag_old,
  output logic [$clog2(rob_depth)-1:0] dispatch_rob_idx,
  output logic                         stall,
  output rename_pkg::phys_reg_t        retire_tag_old,
  output logic                         retire_strobe,
  output logic [$clog2(rob_depth)-1:0] head_idx,
  output logic                         recovering
);

  rob_if #(.rob_depth(rob_depth)) rob_bus ();

  // T comes from the free list front, T_old from the map lookup
  map_table i_map_table (
    .clock          (clock),
    .reset          (reset),
    .port           (rob_bus.map),
    .lookup_dest    (dispatch_dest),
    .lookup_tag_old (dispatch_tag_old),
    .alloc_tag      (dispatch_tag)
  );

  free_list i_free_list (
    .clock     (clock),
    .reset     (reset),
    .port      (rob_bus.free),
    .front_tag (dispatch_tag)
  );

  reorder_buffer #(.rob_depth(rob_depth)) i_rob (
    .clock            (clock),
    .reset            (reset),
    .dispatch         (dispatch),
    .retire           (retire),
    .mispredict       (mispredict),
    .dispatch_dest    (dispatch_dest),
    .branch_idx       (branch_idx),
    .new_tag          (dispatch_tag),
    .new_tag_old      (dispatch_tag_old),
    .port             (rob_bus.rob),
    .dispatch_rob_idx (dispatch_rob_idx),
    .head_idx         (head_idx),
    .stall            (stall),
    .retire_strobe    (retire_strobe),
    .recovering       (recovering),
    .retire_tag_old   (retire_tag_old)
  );

endmodule

`default_nettype wire

/* test/rename_core_tb.sv */
/*
 * Directed tests for rename_core, checked against a model of map, free queue and ROB.
 * Inputs change on the rising edge, outputs are sampled on the falling edge.
 */

`timescale 1ns/1ns
`default_nettype none

module rename_core_tb;

  localparam int rob_depth = 16;
  localparam int idx_w     = $clog2(rob_depth);
  localparam int period    = 8;
  // reset, about eight passes over the ROB across all tests, and margin
  localparam int max_cycles = 8 + 8 * rob_depth + 64;

  logic                  clock;
  logic                  reset;
  logic                  dispatch;
  rename_pkg::arch_reg_t dispatch_dest;
  logic                  retire;
  logic                  mispredict;
  logic [idx_w-1:0]      branch_idx;
  rename_pkg::phys_reg_t dispatch_tag;
  rename_pkg::phys_reg_t dispatch_tag_old;
  logic [idx_w-1:0]      dispatch_rob_idx;
  logic                  stall;
  rename_pkg::phys_reg_t retire_tag_old;
  logic                  retire_strobe;
  logic [idx_w-1:0]      head_idx;
  logic                  recovering;

  // reference model
  rename_pkg::phys_reg_t model_map [rename_pkg::num_arch_regs];
  rename_pkg::phys_reg_t free_q [$];
  rename_pkg::arch_reg_t rob_dest [$];
  rename_pkg::phys_reg_t rob_tag [$];
  rename_pkg::phys_reg_t rob_old [$];
  logic [idx_w-1:0]      model_head;
  logic [idx_w-1:0]      model_tail;

  logic [15:0] lfsr;
  int          errors;
  int          checks;
  int          tests;
  int          start_errors;

  rename_core #(.rob_depth(rob_depth)) i_dut (
    .clock            (clock),
    .reset            (reset),
    .dispatch         (dispatch),
    .dispatch_dest    (dispatch_dest),
    .retire           (retire),
    .mispredict       (mispredict),
    .branch_idx       (branch_idx),
    .dispatch_tag     (dispatch_tag),
    .dispatch_tag_old (dispatch_tag_old),
    .dispatch_rob_idx (dispatch_rob_idx),
    .stall            (stall),
    .retire_tag_old   (retire_tag_old),
    .retire_strobe    (retire_strobe),
    .head_idx         (head_idx),
    .recovering       (recovering)
  );

  always #(period / 2) clock = ~clock;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic rename_pkg::arch_reg_t random_dest();
    rename_pkg::arch_reg_t r;
    logic                  fb;
    r = '0;
    for (int i = 0; i < $bits(r); i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      r    = {r[$bits(r)-2:0], fb};
    end
    return r;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic start_test();
    start_errors = errors;
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("%s: %0d errors", name, errors - start_errors);
  endtask

  // new inputs at the rising edge, return at the falling edge
  task automatic drive(input logic d, input rename_pkg::arch_reg_t dest, input logic r,
                       input logic m, input logic [idx_w-1:0] b);
    @(posedge clock);
    dispatch      <= d;
    dispatch_dest <= dest;
    retire        <= r;
    mispredict    <= m;
    branch_idx    <= b;
    @(negedge clock);
  endtask

  task automatic idle_cycle();
    drive(1'b0, '0, 1'b0, 1'b0, '0);
  endtask

  // dispatch and/or retire in one cycle, checked and mirrored in the model
  task automatic issue(input logic d, input rename_pkg::arch_reg_t dest, input logic r);
    rename_pkg::phys_reg_t t;
    drive(d, dest, r, 1'b0, '0);
    if (d) begin
      check_value("stall", 32'(stall), 0);
      check_value("dispatch_tag", 32'(dispatch_tag), 32'(free_q[0]));
      check_value("dispatch_tag_old", 32'(dispatch_tag_old), 32'(model_map[dest]));
      check_value("dispatch_rob_idx", 32'(dispatch_rob_idx), 32'(model_tail));
    end
    if (r) begin
      check_value("retire_strobe", 32'(retire_strobe), 1);
      check_value("retire_tag_old", 32'(retire_tag_old), 32'(rob_old[0]));
      check_value("head_idx", 32'(head_idx), 32'(model_head));
    end
    if (d) begin
      t = free_q.pop_front();
      rob_dest.push_back(dest);
      rob_tag.push_back(t);
      rob_old.push_back(model_map[dest]);
      model_map[dest] = t;
      model_tail++;
    end
    if (r) begin
      free_q.push_back(rob_old.pop_front());
      void'(rob_dest.pop_front());
      void'(rob_tag.pop_front());
      model_head++;
    end
  endtask

  task automatic test_reset();
    rename_pkg::arch_reg_t r;
    start_test();
    check_value("stall", 32'(stall), 0);
    check_value("recovering", 32'(recovering), 0);
    check_value("retire_strobe", 32'(retire_strobe), 0);
    r = random_dest();
    issue(1'b1, r, 1'b0);
    // outputs still show the accepted dispatch here
    check_value("dispatch_tag", 32'(dispatch_tag), rename_pkg::num_arch_regs);
    check_value("dispatch_tag_old", 32'(dispatch_tag_old), 32'(r));
    check_value("dispatch_rob_idx", 32'(dispatch_rob_idx), 0);
    report_test("reset state and first dispatch");
  endtask

  task automatic test_stream();
    start_test();
    repeat (7) issue(1'b1, random_dest(), 1'b0);
    report_test("random dispatch stream");
  endtask

  task automatic test_fill();
    rename_pkg::arch_reg_t d;
    start_test();
    while (rob_tag.size() < rob_depth) begin
      issue(1'b1, random_dest(), 1'b0);
    end
    idle_cycle();
    check_value("stall", 32'(stall), 1);
    // dispatch into a full ROB is ignored
    d = random_dest();
    drive(1'b1, d, 1'b0, 1'b0, '0);
    check_value("stall", 32'(stall), 1);
    // same destination held so an unwanted map write would show
    drive(1'b0, d, 1'b0, 1'b0, '0);
    check_value("dispatch_tag", 32'(dispatch_tag), 32'(free_q[0]));
    check_value("dispatch_tag_old", 32'(dispatch_tag_old), 32'(model_map[d]));
    check_value("dispatch_rob_idx", 32'(dispatch_rob_idx), 32'(model_tail));
    check_value("head_idx", 32'(head_idx), 32'(model_head));
    report_test("fill to depth and stall");
  endtask

  task automatic test_retire();
    start_test();
    while (rob_tag.size() > 0) begin
      issue(1'b0, '0, 1'b1);
    end
    drive(1'b0, '0, 1'b1, 1'b0, '0);
    check_value("retire_strobe", 32'(retire_strobe), 0);
    // half full, then steady dispatch plus retire until the free queue wraps
    repeat (rob_depth / 2) issue(1'b1, random_dest(), 1'b0);
    repeat (2 * rob_depth) issue(1'b1, random_dest(), 1'b1);
    report_test("in-order retire");
  endtask

  task automatic test_mispredict();
    int                    pos;
    int                    n;
    int                    cycles;
    logic [idx_w-1:0]      b;
    rename_pkg::arch_reg_t undone_dest [$];
    rename_pkg::phys_reg_t first_tag;
    start_test();
    pos = 2;
    b   = model_head + idx_w'(pos);
    n   = rob_tag.size() - pos - 1;
    // the dispatch in the mispredict cycle is dropped
    drive(1'b1, random_dest(), 1'b0, 1'b1, b);
    check_value("recovering", 32'(recovering), 0);
    for (int i = 0; i < n; i++) begin
      undone_dest.push_front(rob_dest.pop_back());
      first_tag = rob_tag.pop_back();
      free_q.push_front(first_tag);
      model_map[undone_dest[0]] = rob_old.pop_back();
    end
    model_tail = b + 1'b1;
    cycles     = 0;
    idle_cycle();
    while (recovering && cycles <= rob_depth) begin
      cycles++;
      check_value("stall", 32'(stall), 1);
      @(negedge clock);
    end
    assert (!recovering) else begin
      $display("recovery walk did not end within %0d cycles", rob_depth);
      errors++;
    end
    check_value("recovering cycles", 32'(cycles), 32'(n));
    for (int i = 0; i < n; i++) begin
      issue(1'b1, undone_dest[i], 1'b0);
      if (i == 0) begin
        check_value("dispatch_tag", 32'(dispatch_tag), 32'(first_tag));
        check_value("dispatch_rob_idx", 32'(dispatch_rob_idx), 32'(idx_w'(b + 1'b1)));
      end
    end
    report_test("mispredict rollback");
  endtask

  task automatic test_youngest();
    logic [idx_w-1:0] b;
    start_test();
    b = model_tail - 1'b1;
    drive(1'b0, '0, 1'b0, 1'b1, b);
    // no younger entries, so no walk at all
    repeat (3) begin
      idle_cycle();
      check_value("recovering", 32'(recovering), 0);
      check_value("dispatch_rob_idx", 32'(dispatch_rob_idx), 32'(model_tail));
    end
    issue(1'b1, random_dest(), 1'b0);
    report_test("mispredict on youngest");
  endtask

  initial begin
    clock         = 1'b0;
    reset         = 1'b1;
    dispatch      = 1'b0;
    dispatch_dest = '0;
    retire        = 1'b0;
    mispredict    = 1'b0;
    branch_idx    = '0;
    lfsr          = 16'd16296;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    model_head    = '0;
    model_tail    = '0;
    for (int i = 0; i < rename_pkg::num_arch_regs; i++) begin
      model_map[i] = rename_pkg::phys_reg_t'(i);
      free_q.push_back(rename_pkg::phys_reg_t'(rename_pkg::num_arch_regs + i));
    end
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    test_reset();
    test_stream();
    test_fill();
    test_retire();
    test_mispredict();
    test_youngest();
    idle_cycle();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    #(max_cycles * period);
    $display("watchdog expired after %0d cycles, tests did not complete", max_cycles);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
rtl/rename_pkg.sv
rtl/rob_if.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/reorder_buffer.sv
rtl/rename_core.sv
test/rename_core_tb.sv

/* Makefile */
# Verilator simulation of the rename back end

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module rename_core_tb -o rename_core_sim
	./obj_dir/rename_core_sim | tee /dev/stderr | grep -qx "test passed"

clean:
	rm -rf obj_dir
